// File: run_sim.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_top -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"

if echo "$out" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1

// File: source/bram_sp.sv
// Single-port word-addressed block RAM with byte strobes and registered read
`timescale 1ns/1ps

module bram_sp #(
  parameter int RAM_DEPTH   = wb_pkg::RAM_DEPTH,
  parameter int RAM_LATENCY = wb_pkg::RAM_LATENCY
) (
  input logic clk_i,
  ram_if.memory mem
);
  import wb_pkg::*;

  // ==============================
  // Storage
  // ==============================
  logic [DATA_W-1:0] mem_q [RAM_DEPTH];
  // Word captured on the read edge
  logic [DATA_W-1:0] rd_q;
  // Output register chain
  logic [DATA_W-1:0] out_q [RAM_LATENCY];

  // Byte lane writes and array read
  always_ff @(posedge clk_i) begin
    for (int b = 0; b < SEL_W; b++) begin
      if (mem.wstrb[b]) begin
        mem_q[mem.addr][8*b +: 8] <= mem.wdata[8*b +: 8];
      end
    end
    if (mem.rd_en) begin
      rd_q <= mem_q[mem.addr];
    end
  end

  // ==============================
  // Read latency stages
  // ==============================
  always_ff @(posedge clk_i) begin
    out_q[0] <= rd_q;
    for (int i = 1; i < RAM_LATENCY; i++) begin
      out_q[i] <= out_q[i-1];
    end
  end

  assign mem.rdata = out_q[RAM_LATENCY-1];

  // Single port, so a cycle is either a read or a write
  a_rd_wr_excl: assert property (
    @(posedge clk_i)
    !(mem.rd_en && (|mem.wstrb))
  );

endmodule

// File: source/ram_if.sv
// Block RAM port interface with controller and memory modports
`timescale 1ns/1ps

interface ram_if;
  import wb_pkg::*;

  // Word address, shared by reads and writes
  logic [RAM_AW-1:0] addr;
  logic [DATA_W-1:0] wdata;
  // Per-lane write enables, all zero on reads
  logic [SEL_W-1:0]  wstrb;
  logic              rd_en;
  // Returned after the full read latency
  logic [DATA_W-1:0] rdata;

  modport controller (
    output addr, wdata, wstrb, rd_en,
    input  rdata
  );

  modport memory (
    input  addr, wdata, wstrb, rd_en,
    output rdata
  );

endinterface

// File: source/wb_addr_decode.sv
// Address decoder with in-order response tracking and error responder
`timescale 1ns/1ps

module wb_addr_decode (
  input logic clk_i,
  input logic rst_ni,
  wb_if.slave  host,
  wb_if.master ram
);
  import wb_pkg::*;

  // Size of the RAM window in bytes
  localparam logic [ADDR_W-1:0] RAM_SPAN = ADDR_W'(RAM_DEPTH * SEL_W);

  // ==============================
  // Region decode
  // ==============================
  logic [ADDR_W-1:0]         rel_adr;
  logic                      in_ram;
  logic                      host_req;
  logic                      hazard_stall;
  logic                      host_acc;
  logic                      rd_acc;
  logic                      unm_acc;
  logic [READ_ACK_DELAY-1:0] rd_pipe;
  logic                      rd_busy;
  logic                      err_q;

  // Offset into the window, wraps for addresses below the base
  assign rel_adr  = host.adr - RAM_BASE;
  assign in_ram   = rel_adr < RAM_SPAN;
  assign host_req = host.cyc && host.stb;

  // ==============================
  // Ordering hazards
  // ==============================

  // Any read still waiting for its ack
  assign rd_busy = |rd_pipe;

  // Only reads may follow reads, nothing may follow an err until it is sent
  assign hazard_stall = host_req && ((rd_busy && (host.we || !in_ram)) || err_q);

  // Ordering hazards plus any backpressure from the RAM slave
  assign host.stall = hazard_stall || ram.stall;

  // Accepted requests by kind
  assign host_acc = host_req && !host.stall;
  assign rd_acc   = host_acc && in_ram && !host.we;
  assign unm_acc  = host_acc && !in_ram;

  // ==============================
  // Forward to RAM slave
  // ==============================
  assign ram.cyc   = host.cyc;
  // Strobe only for accepted RAM hits
  assign ram.stb   = host.stb && in_ram && !host.stall;
  assign ram.we    = host.we;
  assign ram.adr   = host.adr;
  assign ram.dat_w = host.dat_w;
  assign ram.sel   = host.sel;

  // Track reads in flight, one bit per cycle of latency
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      rd_pipe <= '0;
      err_q   <= 1'b0;
    end else begin
      rd_pipe[0] <= rd_acc;
      for (int i = 1; i < READ_ACK_DELAY; i++) begin
        rd_pipe[i] <= rd_pipe[i-1];
      end
      // Error answer goes out one cycle after the unmapped access
      err_q <= unm_acc;
    end
  end

  // ==============================
  // Response steering
  // ==============================
  assign host.dat_r = ram.dat_r;
  assign host.ack   = ram.ack;
  assign host.err   = err_q || ram.err;

  // Responses stay exclusive since hazards serialize them
  a_ack_err_excl: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(host.ack && host.err)
  );

  // Every err traces back to an accepted request past the last RAM word
  a_err_cause: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    host.err |-> $past(host_req && !host.stall &&
                       (((host.adr - RAM_BASE) >> 2) >= RAM_DEPTH))
  );

endmodule

// File: source/wb_if.sv
// Wishbone B4 pipelined bus interface with master and slave modports
`timescale 1ns/1ps

interface wb_if;
  import wb_pkg::*;

  // Request side, driven by the master
  logic              cyc;
  logic              stb;
  logic              we;
  logic [ADDR_W-1:0] adr;
  logic [DATA_W-1:0] dat_w;
  logic [SEL_W-1:0]  sel;

  // Response side, driven by the slave
  logic [DATA_W-1:0] dat_r;
  logic              ack;
  logic              err;
  logic              stall;

  // Request issuer
  modport master (
    output cyc, stb, we, adr, dat_w, sel,
    input  dat_r, ack, err, stall
  );

  // Request target
  modport slave (
    input  cyc, stb, we, adr, dat_w, sel,
    output dat_r, ack, err, stall
  );

endinterface

// File: source/wb_mem_top.sv
// Memory subsystem top with decoder, RAM slave and block RAM
`timescale 1ns/1ps

module wb_mem_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Wishbone request from the master
  input  logic                      wb_cyc_i,
  input  logic                      wb_stb_i,
  input  logic                      wb_we_i,
  input  logic [wb_pkg::ADDR_W-1:0] wb_adr_i,
  input  logic [wb_pkg::DATA_W-1:0] wb_dat_i,
  input  logic [wb_pkg::SEL_W-1:0]  wb_sel_i,
  // Wishbone response to the master
  output logic [wb_pkg::DATA_W-1:0] wb_dat_o,
  output logic                      wb_ack_o,
  output logic                      wb_err_o,
  output logic                      wb_stall_o
);

  // ==============================
  // Internal buses
  // ==============================
  wb_if  host_bus ();
  wb_if  ram_bus ();
  ram_if ram_port ();

  // Host side from the plain ports
  assign host_bus.cyc   = wb_cyc_i;
  assign host_bus.stb   = wb_stb_i;
  assign host_bus.we    = wb_we_i;
  assign host_bus.adr   = wb_adr_i;
  assign host_bus.dat_w = wb_dat_i;
  assign host_bus.sel   = wb_sel_i;

  // Responses back out
  assign wb_dat_o   = host_bus.dat_r;
  assign wb_ack_o   = host_bus.ack;
  assign wb_err_o   = host_bus.err;
  assign wb_stall_o = host_bus.stall;

  // ==============================
  // Pipeline stages
  // ==============================

  // Decode, route and order responses
  wb_addr_decode decode_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .host   (host_bus),
    .ram    (ram_bus)
  );

  // Execute, turn bus cycles into RAM strobes
  wb_ram_slave ram_slave_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .bus    (ram_bus),
    .mem    (ram_port)
  );

  // Storage and read path
  bram_sp bram_i (
    .clk_i (clk_i),
    .mem   (ram_port)
  );

endmodule

// File: source/wb_pkg.sv
// Bus widths, memory map and read latency constants for the memory subsystem
package wb_pkg;

  // ==============================
  // Bus widths
  // ==============================

  // Byte address width on the Wishbone side
  localparam int ADDR_W = 32;

  // Data word width
  localparam int DATA_W = 32;

  // One select bit per byte lane
  localparam int SEL_W = DATA_W / 8;

  // ==============================
  // Memory map
  // ==============================

  // RAM size in 32-bit words
  localparam int RAM_DEPTH = 1024;

  // Word address width into the block RAM
  localparam int RAM_AW = $clog2(RAM_DEPTH);

  // First byte address of the RAM window
  localparam logic [ADDR_W-1:0] RAM_BASE = 32'h0000_0000;

  // ==============================
  // Read timing
  // ==============================

  // Extra output register stages behind the array read
  localparam int RAM_LATENCY = 1;

  // Acceptance to ack for a read, array register plus output stages
  localparam int READ_ACK_DELAY = RAM_LATENCY + 1;

endpackage

// File: source/wb_ram_slave.sv
// Wishbone RAM slave driving block RAM strobes with a read ack pipeline
`timescale 1ns/1ps

module wb_ram_slave #(
  parameter int RAM_DEPTH   = wb_pkg::RAM_DEPTH,
  parameter int RAM_LATENCY = wb_pkg::RAM_LATENCY
) (
  input logic clk_i,
  input logic rst_ni,
  wb_if.slave       bus,
  ram_if.controller mem
);
  import wb_pkg::*;

  // Word address bits actually used by this RAM
  localparam int AW = $clog2(RAM_DEPTH);
  // Array register plus the output stages
  localparam int ACK_DELAY = RAM_LATENCY + 1;

  // ==============================
  // Request decode
  // ==============================
  logic                 req;
  logic                 wr_req;
  logic                 rd_req;
  logic [AW-1:0]        word_adr;
  logic [ACK_DELAY-1:0] ack_pipe;
  logic                 rd_ack;

  assign req    = bus.cyc && bus.stb;
  assign wr_req = req && bus.we;
  assign rd_req = req && !bus.we;

  // Drop the byte offset
  assign word_adr = bus.adr[AW+1:2];

  // ==============================
  // RAM strobes
  // ==============================
  assign mem.addr  = RAM_AW'(word_adr);
  assign mem.wdata = bus.dat_w;
  // Lanes written only on a real write
  assign mem.wstrb = wr_req ? bus.sel : '0;
  assign mem.rd_en = rd_req;

  // Read valid walks alongside the RAM data
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      ack_pipe <= '0;
    end else begin
      ack_pipe[0] <= rd_req;
      for (int i = 1; i < ACK_DELAY; i++) begin
        ack_pipe[i] <= ack_pipe[i-1];
      end
    end
  end

  assign rd_ack = ack_pipe[ACK_DELAY-1];

  // ==============================
  // Wishbone response
  // ==============================

  // Writes ack at once, reads when the data lands
  assign bus.ack   = wr_req || rd_ack;
  assign bus.dat_r = mem.rdata;
  // Ordering and decode errors are handled upstream
  assign bus.stall = 1'b0;
  assign bus.err   = 1'b0;

  // A write ack on top of a read ack would be lost
  a_no_ack_clash: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(wr_req && rd_ack)
  );

endmodule

// File: test/tb_top.sv
// Testbench top with clock, reset, trace driven stimulus, watchdog and final report
`timescale 1ns/1ps

module tb_top;
  import wb_pkg::*;

  localparam int    RESET_CYCLES = 8;
  localparam int    STALL_BOUND  = READ_ACK_DELAY + 1;
  localparam string TRACE_FILE   = "test/wb_trace.txt";

  logic        clk = 1'b0;
  logic        rst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [31:0] wb_adr;
  logic [31:0] wb_dat_w;
  logic [3:0]  wb_sel;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  logic        wb_err;
  logic        wb_stall;

  // Expectation travelling with the current request
  logic        exp_err;
  logic [31:0] exp_dat;
  int          cur_grp;
  int          cur_idx;

  // Trace entries
  int          t_grp[$];
  bit          t_we[$];
  bit          t_err[$];
  bit          t_gap[$];
  logic [31:0] t_adr[$];
  logic [31:0] t_dat[$];
  logic [3:0]  t_sel[$];
  logic [31:0] t_exp[$];

  logic [31:0] lfsr_q;
  int          load_errs = 0;
  bit          trace_loaded = 1'b0;

  always #10 clk = ~clk;

  wb_mem_top dut_i (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .wb_cyc_i   (wb_cyc),
    .wb_stb_i   (wb_stb),
    .wb_we_i    (wb_we),
    .wb_adr_i   (wb_adr),
    .wb_dat_i   (wb_dat_w),
    .wb_sel_i   (wb_sel),
    .wb_dat_o   (wb_dat_r),
    .wb_ack_o   (wb_ack),
    .wb_err_o   (wb_err),
    .wb_stall_o (wb_stall)
  );

  wb_checker chk_i (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .cyc_i     (wb_cyc),
    .stb_i     (wb_stb),
    .we_i      (wb_we),
    .stall_i   (wb_stall),
    .ack_i     (wb_ack),
    .err_i     (wb_err),
    .dat_i     (wb_dat_r),
    .grp_i     (cur_grp),
    .idx_i     (cur_idx),
    .exp_err_i (exp_err),
    .exp_dat_i (exp_dat)
  );

  // Galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // Two bits per gap, one step per bit
  task automatic draw_gap(output int gap);
    gap = 0;
    for (int b = 0; b < 2; b++) begin
      gap    = (gap << 1) | int'(lfsr_q[0]);
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic load_trace();
    int          fd;
    int          n;
    int          grp;
    int          gap;
    string       line;
    string       op;
    string       rsp;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [31:0] exp;
    logic [3:0]  sel;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      load_errs++;
      $display("Error: cannot open trace file %s", TRACE_FILE);
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      // Skip header and blank lines
      if (line.len() < 2 || line.getc(0) == "#") continue;
      n = $sscanf(line, "%d %s %s %d %h %h %h %h", grp, op, rsp, gap, adr, dat, sel, exp);
      if (n != 8) begin
        load_errs++;
        $display("Error: malformed trace line: %s", line);
        continue;
      end
      t_grp.push_back(grp);
      t_we.push_back(op == "W");
      t_err.push_back(rsp == "E");
      t_gap.push_back(gap != 0);
      t_adr.push_back(adr);
      t_dat.push_back(dat);
      t_sel.push_back(sel);
      t_exp.push_back(exp);
    end
    $fclose(fd);
  endtask

  task automatic idle_bus();
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    wb_sel   = '0;
  endtask

  task automatic drive_request(input int k);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = t_we[k];
    wb_adr   = t_adr[k];
    wb_dat_w = t_dat[k];
    wb_sel   = t_sel[k];
    exp_err  = t_err[k];
    exp_dat  = t_exp[k];
    cur_grp  = t_grp[k];
    cur_idx  = k;
  endtask

  // ==============================
  // Main sequence
  // ==============================
  initial begin
    int gap;
    int total;
    rst_n   = 1'b0;
    idle_bus();
    exp_err = 1'b0;
    exp_dat = '0;
    cur_grp = 1;
    cur_idx = -1;
    lfsr_q  = 32'h124df92e;
    load_trace();
    trace_loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // Quiet bus, checker watches for stray responses
    repeat (4) @(negedge clk);
    for (int k = 0; k < t_adr.size(); k++) begin
      drive_request(k);
      // Hold the request until accepted
      @(posedge clk);
      while (wb_stall) @(posedge clk);
      @(negedge clk);
      idle_bus();
      if (t_gap[k]) begin
        draw_gap(gap);
        repeat (gap) @(negedge clk);
      end
    end
    wait (chk_i.pending == 0);
    repeat (4) @(negedge clk);
    chk_i.check_drained();
    total = chk_i.mismatch_cnt + chk_i.other_cnt + load_errs;
    $display("Errors: %0d mismatches, %0d other, %0d trace format", chk_i.mismatch_cnt,
             chk_i.other_cnt, load_errs);
    if (total == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Bound from trace length, worst case stall plus gap plus read latency per entry
  initial begin
    int limit;
    wait (trace_loaded);
    limit = RESET_CYCLES + 8 + t_adr.size() * (STALL_BOUND + 3 + READ_ACK_DELAY + 2);
    repeat (limit) @(posedge clk);
    $display("Error: watchdog timeout after %0d cycles", limit);
    $display("Testbench failed");
    $finish;
  end

endmodule

// File: test/wb_checker.sv
// Response checker that predicts ack, err, timing and read data per accepted request
`timescale 1ns/1ps

module wb_checker #(
  parameter int READ_DELAY = 2
) (
  input logic        clk_i,
  input logic        rst_ni,
  input logic        cyc_i,
  input logic        stb_i,
  input logic        we_i,
  input logic        stall_i,
  input logic        ack_i,
  input logic        err_i,
  input logic [31:0] dat_i,
  input int          grp_i,
  input int          idx_i,
  input logic        exp_err_i,
  input logic [31:0] exp_dat_i
);

  // Kinds: 0 write ack, 1 read ack, 2 err
  int          q_kind[$];
  int          q_acc[$];
  int          q_idx[$];
  int          q_grp[$];
  logic [31:0] q_dat[$];

  int cycle = 0;
  int pending = 0;
  int mismatch_cnt = 0;
  int other_cnt = 0;
  bit wr_stall_seen = 1'b0;

  function automatic string group_name(input int g);
    case (g)
      1:       return "idle_after_reset";
      2:       return "full_word";
      3:       return "partial_write";
      4:       return "read_burst";
      5:       return "write_after_read";
      6:       return "unmapped";
      default: return "unknown";
    endcase
  endfunction

  // ==============================
  // Response compare
  // ==============================
  task automatic compare_response();
    int    kind;
    int    dly;
    string exp_s;
    string act_s;
    if (q_kind.size() == 0) begin
      other_cnt++;
      $display("Error: response in cycle %0d with no request outstanding", cycle);
      return;
    end
    kind  = q_kind.pop_front();
    // Expected distance from acceptance
    dly   = (kind == 0) ? 0 : ((kind == 1) ? READ_DELAY : 1);
    exp_s = (kind == 2) ? "err" : "ack";
    act_s = (ack_i && err_i) ? "ack+err" : (err_i ? "err" : "ack");
    if (act_s != exp_s) begin
      mismatch_cnt++;
      $display("mismatch %s entry %0d response: expected %s actual %s", group_name(q_grp[0]),
               q_idx[0], exp_s, act_s);
    end
    if (cycle - q_acc[0] != dly) begin
      mismatch_cnt++;
      $display("mismatch %s entry %0d latency: expected %0d actual %0d", group_name(q_grp[0]),
               q_idx[0], dly, cycle - q_acc[0]);
    end
    if (kind == 1 && ack_i && dat_i !== q_dat[0]) begin
      mismatch_cnt++;
      $display("mismatch %s entry %0d read data: expected %h actual %h", group_name(q_grp[0]),
               q_idx[0], q_dat[0], dat_i);
    end
    void'(q_acc.pop_front());
    void'(q_idx.pop_front());
    void'(q_grp.pop_front());
    void'(q_dat.pop_front());
  endtask

  always @(posedge clk_i) begin
    cycle++;
    if (rst_ni) begin
      if (stall_i && !(cyc_i && stb_i)) begin
        other_cnt++;
        $display("Error: stall raised in cycle %0d with no request on the bus", cycle);
      end
      // Reads behind reads never wait
      if (cyc_i && stb_i && stall_i && grp_i == 4) begin
        other_cnt++;
        $display("Error: back-to-back read entry %0d was stalled", idx_i);
      end
      if (cyc_i && stb_i && stall_i && we_i && grp_i == 5) begin
        wr_stall_seen = 1'b1;
      end
      // Accepted request, queue what it should get back
      if (cyc_i && stb_i && !stall_i) begin
        q_kind.push_back(exp_err_i ? 2 : (we_i ? 0 : 1));
        q_acc.push_back(cycle);
        q_idx.push_back(idx_i);
        q_grp.push_back(grp_i);
        q_dat.push_back(exp_dat_i);
      end
      if (ack_i || err_i) begin
        compare_response();
      end else if (q_kind.size() > 0 && cycle > q_acc[0] + READ_DELAY + 1) begin
        other_cnt++;
        $display("Error: entry %0d never got a response", q_idx[0]);
        void'(q_kind.pop_front());
        void'(q_acc.pop_front());
        void'(q_idx.pop_front());
        void'(q_grp.pop_front());
        void'(q_dat.pop_front());
      end
      pending = q_kind.size();
    end
  end

  // End of run checks
  task automatic check_drained();
    if (q_kind.size() != 0) begin
      other_cnt++;
      $display("Error: %0d requests still outstanding at the end", q_kind.size());
    end
    if (!wr_stall_seen) begin
      other_cnt++;
      $display("Error: a write right after a read was never stalled");
    end
  endtask

endmodule

// File: test/wb_trace.txt
# Columns: group op resp gap address wdata sel expected_read_data (hex fields)
# op W write or R read, resp A ack or E err, gap 1 random idle after or 0 back to back
2 W A 1 00000000 01234567 f 00000000
2 W A 1 00000004 89abcdef f 00000000
2 W A 0 00000ffc deadbeef f 00000000
2 R A 1 00000000 00000000 f 01234567
2 R A 0 00000004 00000000 f 89abcdef
2 R A 1 00000ffc 00000000 f deadbeef
3 W A 1 00000040 11223344 f 00000000
3 W A 0 00000040 aabbccdd 5 00000000
3 R A 1 00000040 00000000 f 11bb33dd
3 W A 0 00000044 55667788 f 00000000
3 W A 0 00000044 99000000 8 00000000
3 W A 1 00000044 0000aa00 2 00000000
3 R A 1 00000044 00000000 f 9966aa88
2 W A 0 00000100 a0a0a0a0 f 00000000
2 W A 0 00000104 b1b1b1b1 f 00000000
2 W A 0 00000108 c2c2c2c2 f 00000000
2 W A 1 0000010c d3d3d3d3 f 00000000
4 R A 0 0000010c 00000000 f d3d3d3d3
4 R A 0 00000100 00000000 f a0a0a0a0
4 R A 0 00000108 00000000 f c2c2c2c2
4 R A 0 00000104 00000000 f b1b1b1b1
4 R A 1 00000040 00000000 f 11bb33dd
5 R A 0 00000100 00000000 f a0a0a0a0
5 W A 0 00000100 12345678 f 00000000
5 R A 1 00000100 00000000 f 12345678
6 W E 0 00001000 bad0bad0 f 00000000
6 R A 1 00000000 00000000 f 01234567
6 R A 0 00000004 00000000 f 89abcdef
6 W E 0 00001004 0badf00d f 00000000
6 R E 1 fffffffc 00000000 f 00000000
6 R A 1 00000004 00000000 f 89abcdef

// File: verilog.f
source/wb_pkg.sv
source/wb_if.sv
source/ram_if.sv
source/wb_addr_decode.sv
source/wb_ram_slave.sv
source/bram_sp.sv
source/wb_mem_top.sv
test/wb_checker.sv
test/tb_top.sv
